/* game_top.f */
+incdir+src
src/vga_pkg.sv
src/game_pkg.sv
src/vga_timing.sv
src/player_ctl.sv
src/game_fsm.sv
src/frame_render.sv
src/game_top.sv
testbench/game_chk.sv
testbench/game_tb.sv

/* src/frame_render.sv */
/* Drawing stage. Picks the colour of each pixel from the game state and the
   paddle positions and registers it together with the syncs. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module frame_render import vga_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  vga_tim_t    tim,
    input  game_state_e state,
    input  xpos_t       xpos1,
    input  xpos_t       xpos2,
    output vga_px_t     px
);

    localparam xpos_t PW     = xpos_t'(`PADDLE_W);
    localparam xpos_t BAND_H = xpos_t'(2);
    localparam xpos_t P1_Y   = xpos_t'(`P1_ROW);
    localparam xpos_t P2_Y   = xpos_t'(`P2_ROW);

    localparam rgb_t BLACK = 12'h000;
    localparam rgb_t BLUE  = 12'h00F;
    localparam rgb_t GREY  = 12'h888;
    localparam rgb_t RED   = 12'hF00;
    localparam rgb_t GREEN = 12'h0F0;

    logic on_p1;
    logic on_p2;
    rgb_t colour;

    always_comb begin
        on_p1 = (tim.vcount >= P1_Y) && (tim.vcount < P1_Y + BAND_H) &&
                (tim.hcount >= xpos1) && (tim.hcount < xpos1 + PW);
        on_p2 = (tim.vcount >= P2_Y) && (tim.vcount < P2_Y + BAND_H) &&
                (tim.hcount >= xpos2) && (tim.hcount < xpos2 + PW);
    end

    always_comb begin
        colour = BLACK;
        if (!tim.blank) begin
            if (state == START) begin
                colour = BLUE;                 // Title screen has no paddles
            end else if (on_p1) begin
                colour = RED;
            end else if (on_p2) begin
                colour = GREEN;
            end else if (state == OVER) begin
                colour = GREY;
            end
        end
    end

    // Syncs go through the same stage so they stay aligned with rgb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            px.hsync <= 1'b1;
            px.vsync <= 1'b1;
            px.rgb   <= BLACK;
        end else begin
            px.hsync <= tim.hsync;
            px.vsync <= tim.vsync;
            px.rgb   <= colour;
        end
    end

endmodule

`default_nettype wire

/* src/game_cfg.svh */
/* Video mode, paddle geometry and motion settings for the paddle game core.
   Included by the packages and by any module that needs a raw dimension. */

`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Horizontal segments in pixels, scaled down from 800 x 600 SVGA
`define H_ACTIVE    32
`define H_FP        2
`define H_SYNC      4
`define H_BP        2

// Vertical segments in lines
`define V_ACTIVE    24
`define V_FP        1
`define V_SYNC      2
`define V_BP        1

`define PADDLE_W    6     // Paddle width in pixels
`define PADDLE_STEP 2     // Pixels moved per frame while a button is held

// First line of each two-line paddle band
`define P1_ROW      18
`define P2_ROW      21

`define P1_START    0
`define P2_START    26

`define COUNT_W     11    // Wide enough for the full SVGA timing as well

`endif

/* src/game_fsm.sv */
/* Game state machine. Samples the start button once per frame, detects
   presses and ends the round when the two paddles overlap. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module game_fsm import game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        frame_start,
    input  logic        start_btn,
    input  xpos_t       xpos1,
    input  xpos_t       xpos2,
    output game_state_e state,
    output logic        restart
);

    localparam xpos_t PW = xpos_t'(`PADDLE_W);

    logic start_prev;    // Start level at the previous frame start
    logic start_press;
    logic overlap;

    assign start_press = start_btn && !start_prev;

    // Ranges [x, x+PW-1] share at least one column
    assign overlap = (xpos1 < xpos2 + PW) && (xpos2 < xpos1 + PW);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= START;
            restart    <= 1'b0;
            start_prev <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (frame_start) begin
                start_prev <= start_btn;
                case (state)
                    START: begin
                        if (start_press) begin
                            state   <= PLAY;
                            restart <= 1'b1;   // Paddles back to their start columns
                        end
                    end
                    PLAY: begin
                        if (overlap) begin
                            state <= OVER;
                        end
                    end
                    OVER: begin
                        if (start_press) begin
                            state <= START;
                        end
                    end
                    default: begin
                        state <= START;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/game_pkg.sv */
/* Game level types used by the state machine, the player controllers
   and the renderer. Import with game_pkg::* in the module header. */

`default_nettype none

`include "game_cfg.svh"

package game_pkg;

    // Title screen, round in progress, round lost
    typedef enum logic [1:0] {
        START = 2'd0,
        PLAY  = 2'd1,
        OVER  = 2'd2
    } game_state_e;

    // Button levels of one player, high while pressed
    typedef struct packed {
        logic left;
        logic right;
    } paddle_btn_t;

    // Left edge of a paddle in pixels
    typedef logic [`COUNT_W-1:0] xpos_t;

endpackage

`default_nettype wire

/* src/game_top.sv */
/* Top level of the two player paddle game. Joins the timing generator,
   both player controllers, the game state machine and the drawing stage. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module game_top import vga_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start_btn,
    input  paddle_btn_t p1_btn,
    input  paddle_btn_t p2_btn,
    output logic        hs,
    output logic        vs,
    output rgb_t        rgb
);

    vga_tim_t    tim;
    vga_px_t     px;
    game_state_e state;
    logic        restart;
    xpos_t       xpos1;
    xpos_t       xpos2;

    assign hs  = px.hsync;
    assign vs  = px.vsync;
    assign rgb = px.rgb;

    vga_timing u_vga_timing (
        .clk    (clk),
        .arst_n (arst_n),
        .tim    (tim)
    );

    player_ctl #(
        .START_X (xpos_t'(`P1_START))
    ) u_player1 (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (tim.frame_start),
        .btn         (p1_btn),
        .state       (state),
        .restart     (restart),
        .xpos        (xpos1)
    );

    player_ctl #(
        .START_X (xpos_t'(`P2_START))
    ) u_player2 (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (tim.frame_start),
        .btn         (p2_btn),
        .state       (state),
        .restart     (restart),
        .xpos        (xpos2)
    );

    game_fsm u_game_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (tim.frame_start),
        .start_btn   (start_btn),
        .xpos1       (xpos1),
        .xpos2       (xpos2),
        .state       (state),
        .restart     (restart)
    );

    frame_render u_frame_render (
        .clk    (clk),
        .arst_n (arst_n),
        .tim    (tim),
        .state  (state),
        .xpos1  (xpos1),
        .xpos2  (xpos2),
        .px     (px)
    );

endmodule

`default_nettype wire

/* src/player_ctl.sv */
/* Paddle position of one player. Steps once per frame in PLAY toward the
   single pressed direction and stays inside the visible width. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module player_ctl import game_pkg::*; #(
    parameter xpos_t START_X = '0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        frame_start,
    input  paddle_btn_t btn,
    input  game_state_e state,
    input  logic        restart,
    output xpos_t       xpos
);

    localparam xpos_t X_MAX = xpos_t'(`H_ACTIVE - `PADDLE_W);
    localparam xpos_t STEP  = xpos_t'(`PADDLE_STEP);

    xpos_t xpos_nxt;

    always_comb begin
        xpos_nxt = xpos;
        if (btn.left && !btn.right) begin
            if (xpos < STEP) begin
                xpos_nxt = '0;                   // Clamp at the left edge
            end else begin
                xpos_nxt = xpos - STEP;
            end
        end else if (btn.right && !btn.left) begin
            if (xpos > X_MAX - STEP) begin
                xpos_nxt = X_MAX;
            end else begin
                xpos_nxt = xpos + STEP;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xpos <= START_X;
        end else if (restart) begin
            xpos <= START_X;                     // New round
        end else if (frame_start && state == PLAY) begin
            xpos <= xpos_nxt;
        end
    end

endmodule

`default_nettype wire

/* src/vga_pkg.sv */
/* Video types shared by the timing generator, the renderer and the top level.
   Import with vga_pkg::* in the module header. */

`default_nettype none

`include "game_cfg.svh"

package vga_pkg;

    // One entry per pixel clock, produced by vga_timing
    typedef struct packed {
        logic [`COUNT_W-1:0] hcount;
        logic [`COUNT_W-1:0] vcount;
        logic                hsync;       // Active low
        logic                vsync;       // Active low
        logic                blank;
        logic                frame_start; // High at (0,0) only
    } vga_tim_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // What leaves the chip
    typedef struct packed {
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } vga_px_t;

endpackage

`default_nettype wire

/* src/vga_timing.sv */
/* Pixel timing generator. Free running horizontal and vertical counters
   with registered syncs, blanking and a one cycle frame start pulse. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module vga_timing import vga_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    output vga_tim_t tim
);

    localparam int H_TOTAL   = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL   = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int H_SYNC_LO = `H_ACTIVE + `H_FP;
    localparam int H_SYNC_HI = H_SYNC_LO + `H_SYNC;
    localparam int V_SYNC_LO = `V_ACTIVE + `V_FP;
    localparam int V_SYNC_HI = V_SYNC_LO + `V_SYNC;

    logic [`COUNT_W-1:0] hcount;
    logic [`COUNT_W-1:0] vcount;
    logic                h_last;
    logic                v_last;

    assign h_last = (hcount == `COUNT_W'(H_TOTAL - 1));
    assign v_last = (vcount == `COUNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                if (v_last) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Output stage follows the counters by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tim.hcount      <= '0;
            tim.vcount      <= '0;
            tim.hsync       <= 1'b1;
            tim.vsync       <= 1'b1;
            tim.blank       <= 1'b0;
            tim.frame_start <= 1'b0;
        end else begin
            tim.hcount      <= hcount;
            tim.vcount      <= vcount;
            tim.hsync       <= !((hcount >= `COUNT_W'(H_SYNC_LO)) &&
                                 (hcount <  `COUNT_W'(H_SYNC_HI)));
            tim.vsync       <= !((vcount >= `COUNT_W'(V_SYNC_LO)) &&
                                 (vcount <  `COUNT_W'(V_SYNC_HI)));
            tim.blank       <= (hcount >= `COUNT_W'(`H_ACTIVE)) ||
                               (vcount >= `COUNT_W'(`V_ACTIVE));
            tim.frame_start <= (hcount == '0) && (vcount == '0);
        end
    end

endmodule

`default_nettype wire

/* testbench/game_chk.sv */
/* Concurrent checks on the VGA pins of the paddle game core.
   Bound to game_top from the testbench. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module game_chk import vga_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     hs,
    input logic     vs,
    input rgb_t     rgb,
    input vga_tim_t tim
);

    int unsigned fail_count;

    initial fail_count = 0;

    // Line sync pulse is exactly H_SYNC pixels wide
    a_hsync_width: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(hs) |-> !hs [*`H_SYNC] ##1 hs)
        else begin
            fail_count++;
            $error("hs low for a different number of cycles than the sync width");
        end

    // A line starts H_BP pixels after hs returns high
    a_vsync_at_line_start: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(vs) |-> $past(hs, `H_BP) && !$past(hs, `H_BP + 1))
        else begin
            fail_count++;
            $error("vs changed away from a line start");
        end

    a_blank_is_black: assert property (@(posedge clk) disable iff (!arst_n)
        $past(tim.blank) |-> (rgb == '0))     // Pins trail the timing bus by one stage
        else begin
            fail_count++;
            $error("rgb not zero during blanking");
        end

endmodule

`default_nettype wire

/* testbench/game_golden.txt */
# start p1_left p1_right p2_left p2_right expected_state expected_x1 expected_x2
# state 0 START, 1 PLAY, 2 OVER; paddle columns are only drawn outside START
0 0 0 0 0  0  0 26
0 0 0 0 0  0  0 26
1 0 0 0 0  1  0 26
1 0 0 0 0  1  0 26
0 0 1 0 0  1  2 26
0 0 1 0 0  1  4 26
0 1 1 0 0  1  4 26
0 1 0 0 1  1  2 26
0 1 0 0 0  1  0 26
0 1 0 0 0  1  0 26
0 0 1 1 0  1  2 24
0 0 0 1 1  1  2 24
0 0 1 1 0  1  4 22
0 0 1 1 0  1  6 20
0 0 1 1 0  1  8 18
0 0 1 1 0  1 10 16
0 0 1 1 0  1 12 14
0 0 0 0 0  2 12 14
0 1 0 0 0  2 12 14
1 0 0 0 0  0 12 14
1 0 0 0 0  0 12 14
0 0 0 0 0  0 12 14
1 0 0 0 0  1  0 26
0 0 0 0 1  1  0 26

/* testbench/game_tb.sv */
/* Testbench for the paddle game core. Replays one line of button levels per frame
   from the golden file and checks the state and paddle columns seen on the pins. */

`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module game_tb import vga_pkg::*, game_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int STIM_DELAY   = 10;
    localparam int FRAME_CYCLES = (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP) *
                                  (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP);

    localparam rgb_t BLACK = 12'h000;
    localparam rgb_t BLUE  = 12'h00F;
    localparam rgb_t GREY  = 12'h888;
    localparam rgb_t RED   = 12'hF00;
    localparam rgb_t GREEN = 12'h0F0;

    typedef struct {
        logic        start;
        paddle_btn_t p1;
        paddle_btn_t p2;
        game_state_e state;
        xpos_t       x1;
        xpos_t       x2;
    } vector_t;

    logic        clk;
    logic        arst_n;
    logic        start_btn;
    paddle_btn_t p1_btn;
    paddle_btn_t p2_btn;
    logic        hs;
    logic        vs;
    rgb_t        rgb;

    vector_t     vectors[$];
    rgb_t        frame[`V_ACTIVE][`H_ACTIVE];
    logic        loaded;
    game_state_e state_seen;

    game_top u_game_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .start_btn (start_btn),
        .p1_btn    (p1_btn),
        .p2_btn    (p2_btn),
        .hs        (hs),
        .vs        (vs),
        .rgb       (rgb)
    );

    bind game_top game_chk u_game_chk (
        .clk    (clk),
        .arst_n (arst_n),
        .hs     (hs),
        .vs     (vs),
        .rgb    (rgb),
        .tim    (tim)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_golden();
        int      fd;
        int      n;
        int      f[8];
        string   line;
        vector_t v;
        fd = $fopen("testbench/game_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file testbench/game_golden.txt");
            $display("Done: errors found");
            $fatal(1);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    if (n == 8) begin
                        v.start = f[0][0];
                        v.p1    = '{left: f[1][0], right: f[2][0]};
                        v.p2    = '{left: f[3][0], right: f[4][0]};
                        v.state = game_state_e'(f[5][1:0]);
                        v.x1    = xpos_t'(f[6]);
                        v.x2    = xpos_t'(f[7]);
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_vs_fall();
        while (vs !== 1'b1) @(negedge clk);
        while (vs !== 1'b0) @(negedge clk);
    endtask

    // Ends on the first sample with hs high again
    task automatic wait_hs_rise();
        while (hs !== 1'b0) @(negedge clk);
        while (hs !== 1'b1) @(negedge clk);
    endtask

    task automatic capture_frame();
        int r;
        int c;
        while (vs !== 1'b1) @(negedge clk);
        repeat (`V_BP) wait_hs_rise();      // Last back porch line leads into row 0
        for (r = 0; r < `V_ACTIVE; r++) begin
            if (r > 0) begin
                wait_hs_rise();
            end
            repeat (`H_BP - 1) @(negedge clk);
            for (c = 0; c < `H_ACTIVE; c++) begin
                @(negedge clk);
                frame[r][c] = rgb;
            end
        end
    endtask

    // The very first pixel is drawn before the frame start update lands
    task automatic read_state(output game_state_e st);
        rgb_t px;
        px = frame[1][0];
        st = START;
        case (px)
            BLUE:  st = START;
            BLACK: st = PLAY;
            GREY:  st = OVER;
            default: begin
                $display("Background colour %h matches no game state", px);
                $display("Done: errors found");
                $fatal(1);
            end
        endcase
    endtask

    function automatic xpos_t first_column(int row, rgb_t colour);
        xpos_t col;
        int    c;
        col = xpos_t'(`H_ACTIVE);              // Paddle not drawn on this row
        for (c = `H_ACTIVE - 1; c >= 0; c--) begin
            if (frame[row][c] == colour) begin
                col = xpos_t'(c);
            end
        end
        return col;
    endfunction

    task automatic check_state(string name, game_state_e exp, game_state_e act);
        if (act !== exp) begin
            $display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_x(string name, xpos_t exp, xpos_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    initial begin
        wait (loaded);
        #((vectors.size() * 2 + 4) * FRAME_CYCLES * CLK_PERIOD);
        $display("Run timed out while waiting for sync pulses from the DUT");
        $display("Done: errors found");
        $fatal(1);
    end

    // Stops the run as soon as a pin assertion fails
    always @(u_game_top.u_game_chk.fail_count) begin
        if (u_game_top.u_game_chk.fail_count != 0) begin
            $display("A pin assertion on hs, vs or rgb failed");
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        start_btn = 1'b0;
        p1_btn    = '0;
        p2_btn    = '0;
        loaded    = 1'b0;
        load_golden();
        if (vectors.size() == 0) begin
            $display("The golden file holds no usable lines");
            $display("Done: errors found");
            $fatal(1);
        end
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #STIM_DELAY arst_n = 1'b1;

        // Levels set during vsync are sampled at the next frame start
        foreach (vectors[i]) begin
            wait_vs_fall();
            @(posedge clk);
            #STIM_DELAY;
            start_btn = vectors[i].start;
            p1_btn    = vectors[i].p1;
            p2_btn    = vectors[i].p2;
            capture_frame();
            read_state(state_seen);
            check_state($sformatf("frame %0d state", i + 1), vectors[i].state, state_seen);
            if (vectors[i].state != START) begin
                check_x($sformatf("frame %0d p1 x", i + 1), vectors[i].x1,
                        first_column(`P1_ROW, RED));
                check_x($sformatf("frame %0d p2 x", i + 1), vectors[i].x2,
                        first_column(`P2_ROW, GREEN));
            end
        end

        if (u_game_top.u_game_chk.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Pin checker reported %0d assertion failures",
                     u_game_top.u_game_chk.fail_count);
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
